// ==== Bender.yml ====
package:
  name: dac_ctrl

sources:
  - files:
      - hw/dac_ctrl_pkg.sv
      - hw/dac_word_build.sv
      - hw/dac_init_seq.sv
      - hw/dac_serial_out.sv
      - hw/dac_ctrl_top.sv
  - target: test
    files:
      - bench/dac_ctrl_check.sv
      - bench/dac_ctrl_tb.sv

// ==== bench/dac_ctrl_check.sv ====
`timescale 1ns/10ps

module dac_ctrl_check import dac_ctrl_pkg::*; #(
	parameter int unsigned WAIT_LEN = 31
) (
	input logic clk_s,
	input logic rst,
	input logic busy,
	input logic dac_rst,
	input logic mc,
	input logic md,
	input logic ml
);

	localparam int WORD_PERIOD = 2 * WORD_BITS + WAIT_LEN + 1; // shift plus gap
	localparam int PWR_BASE    = WAIT_LEN + 3; // dac_rst, settle, one mc low half
	localparam int PWR_LEN     = 1 + (WAIT_LEN + 1) + 3 * WORD_PERIOD;
	localparam int LATCH_OFS   = 2 * WORD_BITS + 1; // first mc high to third gap cycle

	logic [WORD_BITS-1:0] exp_q[$];      // three words per expected sequence
	bit                   with_rst_q[$]; // power-up or reload
	logic [WORD_BITS-1:0] exp_cur [0:2];
	logic [WORD_BITS-1:0] shreg;
	bit                   cur_with_rst;
	bit                   in_seq = 1'b0;

	logic busy_d = 1'b0;
	logic mc_d   = 1'b0;
	logic md_d   = 1'b0;
	logic ml_d   = 1'b1;

	int seq_idx;  // busy cycle index inside the sequence
	int base;     // cycle of the first mc high
	int word_idx;
	int bit_idx;
	int rst_pulses;
	int exp_idx;
	int exp_len;

	int seq_cnt      = 0;
	int word_cnt     = 0;
	int mismatch_cnt = 0;
	int fault_cnt    = 0;

	function automatic logic [WORD_BITS-1:0] pack_word(input logic [1:0] mode_num,
		input logic [ATT_W-1:0] data);
		return {3'b000, mode_num, data};
	endfunction

	// called by the bench whenever it starts a sequence
	task automatic expect_sequence(input logic [ATT_W-1:0] al, input logic [ATT_W-1:0] ar,
		input dac_func_t f, input bit with_rst);
		exp_q.push_back(pack_word(2'd0, al));
		exp_q.push_back(pack_word(2'd1, ar));
		// function word: out mode, zero reset bit, then the other eight bits
		exp_q.push_back(pack_word(2'd2, {f.out_mode, 1'b0, f.word_len, f.zero_mode,
			f.atten_common, f.mute, f.emph}));
		with_rst_q.push_back(with_rst);
	endtask

	task automatic report_fault(input string msg);
		$display("at %0t: %s", $time, msg);
		fault_cnt++;
	endtask

	always @(posedge clk_s) begin
		if (rst) begin
			in_seq = 1'b0;
			busy_d = 1'b0;
			mc_d   = 1'b0;
			md_d   = 1'b0;
			ml_d   = 1'b1;
		end else begin
			if (busy && !busy_d) begin
				if (with_rst_q.size() == 0) begin
					report_fault("busy rose although no sequence was started");
					cur_with_rst = 1'b0;
				end else begin
					cur_with_rst = with_rst_q.pop_front();
					for (int i = 0; i < 3; i++) begin
						exp_cur[i] = exp_q.pop_front();
					end
				end
				in_seq     = 1'b1;
				seq_idx    = 0;
				word_idx   = 0;
				bit_idx    = 0;
				rst_pulses = 0;
				base       = cur_with_rst ? PWR_BASE : 1;
			end

			if (in_seq && busy) begin
				if (dac_rst) begin
					rst_pulses++;
					if (seq_idx != 0)
						report_fault($sformatf("dac_rst high in cycle %0d of the sequence",
							seq_idx));
				end
				if (mc && mc_d)
					report_fault("mc stayed high for more than one cycle");
				if (mc && !mc_d) begin
					exp_idx = base + word_idx * WORD_PERIOD + 2 * bit_idx;
					if (word_idx > 2 || bit_idx >= WORD_BITS)
						report_fault("mc pulse beyond three words of 16 bits");
					else if (seq_idx != exp_idx)
						report_fault($sformatf("mc rose in cycle %0d, expected cycle %0d",
							seq_idx, exp_idx));
					if (md != md_d)
						report_fault("md changed between the two halves of a bit");
					shreg = {shreg[WORD_BITS-2:0], md}; // MSB first
					bit_idx++;
				end
				if (!ml && !ml_d) begin
					report_fault("ml stayed low for more than one cycle");
				end else if (!ml) begin
					exp_idx = base + word_idx * WORD_PERIOD + LATCH_OFS;
					if (bit_idx != WORD_BITS)
						report_fault($sformatf("ml pulsed after %0d bits", bit_idx));
					if (seq_idx != exp_idx)
						report_fault($sformatf("ml low in cycle %0d, expected cycle %0d",
							seq_idx, exp_idx));
					if (word_idx > 2) begin
						report_fault("more than three words latched in one sequence");
					end else if (shreg !== exp_cur[word_idx]) begin
						$display("Mismatch at %0t: word %0d of sequence %0d expected %h got %h",
							$time, word_idx, seq_cnt, exp_cur[word_idx], shreg);
						mismatch_cnt++;
					end
					word_idx++;
					word_cnt++;
					bit_idx = 0;
				end
				seq_idx++;
			end

			if (in_seq && !busy) begin
				exp_len = cur_with_rst ? PWR_LEN : 3 * WORD_PERIOD;
				if (seq_idx != exp_len)
					report_fault($sformatf("busy lasted %0d cycles instead of %0d",
						seq_idx, exp_len));
				if (word_idx != 3)
					report_fault($sformatf("sequence latched %0d words instead of 3", word_idx));
				if (rst_pulses != (cur_with_rst ? 1 : 0))
					report_fault($sformatf("dac_rst was high for %0d cycles", rst_pulses));
				in_seq = 1'b0;
				seq_cnt++;
			end

			// port at rest between sequences
			if (!busy && (mc || md || !ml || dac_rst))
				report_fault("pins not at idle levels while not busy");

			busy_d = busy;
			mc_d   = mc;
			md_d   = md;
			ml_d   = ml;
		end
	end

endmodule

// ==== bench/dac_ctrl_tb.sv ====
`timescale 1ns/10ps

module dac_ctrl_tb import dac_ctrl_pkg::*; ();

	localparam int unsigned WAIT_LEN = 31;
	localparam int N_RELOAD   = 4;
	localparam int N_SEQ      = 3 + N_RELOAD; // power-up, snapshot, reloads, ignored
	localparam int SEQ_CYCLES = 225;
	localparam int LIMIT      = (N_SEQ + 2) * SEQ_CYCLES * (WAIT_LEN + 1) / 32;

	logic             clk_s = 1'b0;
	logic             rst;
	logic             reload;
	logic [ATT_W-1:0] att_l;
	logic [ATT_W-1:0] att_r;
	dac_func_t        func;
	logic             busy;
	logic             dac_rst;
	logic             mc;
	logic             md;
	logic             ml;

	integer seed;
	integer hold;
	int     cycles     = 0;
	int     tb_errs    = 0;
	int     seq_issued = 0;
	int     err_mark   = 0;

	always #10 clk_s = ~clk_s;

	dac_ctrl_top #(
		.WAIT_LEN (WAIT_LEN)
	) UUT (
		.clk_s   (clk_s),
		.rst     (rst),
		.att_l   (att_l),
		.att_r   (att_r),
		.func    (func),
		.reload  (reload),
		.busy    (busy),
		.dac_rst (dac_rst),
		.mc      (mc),
		.md      (md),
		.ml      (ml)
	);

	dac_ctrl_check #(
		.WAIT_LEN (WAIT_LEN)
	) u_check (
		.clk_s   (clk_s),
		.rst     (rst),
		.busy    (busy),
		.dac_rst (dac_rst),
		.mc      (mc),
		.md      (md),
		.ml      (ml)
	);

	function automatic int total_errors();
		return u_check.mismatch_cnt + u_check.fault_cnt + tb_errs;
	endfunction

	task automatic randomize_settings();
		integer r;
		r = $random(seed);
		att_l = r[ATT_W-1:0];
		r = $random(seed);
		att_r = r[ATT_W-1:0];
		r = $random(seed);
		func = dac_func_t'(r[$bits(dac_func_t)-1:0]);
	endtask

	// new settings with the strobe, the model gets the same values
	task automatic start_reload();
		randomize_settings();
		reload = 1'b1;
		u_check.expect_sequence(att_l, att_r, func, 1'b0);
		seq_issued++;
		@(negedge clk_s);
		reload = 1'b0;
	endtask

	task automatic strobe_while_busy();
		randomize_settings();
		if (!busy) begin
			$display("at %0t: sequence ended before the extra reload strobe", $time);
			tb_errs++;
		end
		reload = 1'b1;
		@(negedge clk_s);
		reload = 1'b0;
	endtask

	task automatic wait_busy();
		do @(negedge clk_s); while (!busy);
	endtask

	task automatic wait_idle();
		while (busy) @(negedge clk_s);
		repeat (2) @(negedge clk_s); // checker closes the sequence one edge later
	endtask

	task automatic report_test(input string name);
		int now_errs;
		now_errs = total_errors();
		if (now_errs == err_mark)
			$display("test %s: ok", name);
		else
			$display("test %s: FAILED with %0d new errors", name, now_errs - err_mark);
		err_mark = now_errs;
	endtask

	always @(posedge clk_s) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: run still going after %0d cycles", LIMIT);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		seed   = 32'hd014_5bd4;
		rst    = 1'b1;
		reload = 1'b0;
		randomize_settings();

		repeat (5) @(negedge clk_s);
		u_check.expect_sequence(att_l, att_r, func, 1'b1);
		seq_issued++;
		rst = 1'b0;
		wait_busy();
		wait_idle();
		report_test("power-up");

		// settings change twice while the words go out
		start_reload();
		wait_busy();
		repeat (20) @(negedge clk_s);
		randomize_settings();
		repeat (70) @(negedge clk_s);
		randomize_settings();
		wait_idle();
		report_test("snapshot");

		for (int i = 0; i < N_RELOAD; i++) begin
			start_reload();
			wait_busy();
			wait_idle();
		end
		report_test("reload");

		start_reload();
		wait_busy();
		strobe_while_busy();
		hold = $random(seed);
		repeat (hold[6:0]) @(negedge clk_s);
		strobe_while_busy();
		wait_idle();
		repeat (10) @(negedge clk_s); // a restart would show up here
		report_test("ignored reload");

		if (u_check.seq_cnt != seq_issued) begin
			$display("checker saw %0d sequences, bench started %0d", u_check.seq_cnt, seq_issued);
			tb_errs++;
		end
		if (u_check.word_cnt != 3 * seq_issued) begin
			$display("checker saw %0d words, expected %0d", u_check.word_cnt, 3 * seq_issued);
			tb_errs++;
		end
		report_test("framing and counts");

		$display("summary: %0d sequences, %0d words, %0d mismatches, %0d faults, %0d bench errors",
			u_check.seq_cnt, u_check.word_cnt, u_check.mismatch_cnt, u_check.fault_cnt, tb_errs);
		if (total_errors() == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== dac_ctrl.f ====
hw/dac_ctrl_pkg.sv
hw/dac_word_build.sv
hw/dac_init_seq.sv
hw/dac_serial_out.sv
hw/dac_ctrl_top.sv
bench/dac_ctrl_check.sv
bench/dac_ctrl_tb.sv

// ==== hw/dac_ctrl_pkg.sv ====
package dac_ctrl_pkg;

	// attenuation field width, same for left and right
	localparam int ATT_W = 11;

	// bits per control word on the mode port
	localparam int WORD_BITS = 16;

	// which control word is on the wire
	typedef enum logic [1:0] {
		MODE_ATT_L = 2'd0,
		MODE_ATT_R = 2'd1,
		MODE_FUNC  = 2'd2
	} dac_mode_e;

	// function settings, field order follows the word layout
	typedef struct packed {
		logic [1:0] out_mode;     // output phase / channel routing
		logic [1:0] word_len;     // input word length select
		logic [1:0] zero_mode;    // zero detect pin behavior
		logic       atten_common; // one attenuation for both channels
		logic       mute;
		logic [1:0] emph;         // de-emphasis select
	} dac_func_t;

	// one control word, MSB first on md
	typedef struct packed {
		logic [2:0]       reserved; // always zero
		logic [1:0]       mode;     // mode number of this word
		logic [ATT_W-1:0] data;
	} dac_word_t;

	// one-cycle strobes from sequencer to serial driver
	typedef struct packed {
		logic dac_rst; // pulse the DAC reset pin
		logic load;    // capture a new word and start shifting
		logic latch;   // drop ml for one cycle
	} seq_ctl_t;

endpackage

// ==== hw/dac_ctrl_top.sv ====
`timescale 1ns/10ps

module dac_ctrl_top import dac_ctrl_pkg::*; #(
	parameter int unsigned WAIT_LEN = 31 // last settle / gap count
) (
	input  logic             clk_s,
	input  logic             rst,
	input  logic [ATT_W-1:0] att_l,
	input  logic [ATT_W-1:0] att_r,
	input  dac_func_t        func,
	input  logic             reload,
	output logic             busy,
	output logic             dac_rst,
	output logic             mc,
	output logic             md,
	output logic             ml
);

	logic      snap;
	dac_mode_e mode;
	seq_ctl_t  ctl;
	dac_word_t word;

	// decode
	dac_word_build u_build (
		.clk_s (clk_s),
		.rst   (rst),
		.snap  (snap),
		.att_l (att_l),
		.att_r (att_r),
		.func  (func),
		.mode  (mode),
		.word  (word)
	);

	// execute
	dac_init_seq #(
		.WAIT_LEN (WAIT_LEN)
	) u_seq (
		.clk_s  (clk_s),
		.rst    (rst),
		.reload (reload),
		.snap   (snap),
		.mode   (mode),
		.ctl    (ctl),
		.busy   (busy)
	);

	// result, all pins come from here
	dac_serial_out u_ser (
		.clk_s   (clk_s),
		.rst     (rst),
		.ctl     (ctl),
		.word    (word),
		.dac_rst (dac_rst),
		.mc      (mc),
		.md      (md),
		.ml      (ml)
	);

endmodule

// ==== hw/dac_init_seq.sv ====
`timescale 1ns/10ps

module dac_init_seq import dac_ctrl_pkg::*; #(
	parameter int unsigned WAIT_LEN = 31
) (
	input  logic      clk_s,
	input  logic      rst,
	input  logic      reload,
	output logic      snap,
	output dac_mode_e mode,
	output seq_ctl_t  ctl,
	output logic      busy
);

	localparam logic [7:0] WAIT_LAST  = 8'(WAIT_LEN);
	localparam logic [7:0] LATCH_SLOT = 8'd2;  // third gap cycle on the pins
	localparam logic [4:0] SHIFT_LAST = 5'd31; // two cycles per bit, 16 bits

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RST,
		ST_RST_WAIT,
		ST_SHIFT,
		ST_SHIFT_WAIT
	} seq_state_e;

	seq_state_e state;
	logic [7:0] wait_cnt;  // settle and gap counter
	logic [4:0] shift_cnt; // cycles into the current word

	always_ff @(posedge clk_s) begin
		if (rst) begin
			state     <= ST_RST; // reset strobe goes out as reset is released
			wait_cnt  <= '0;
			shift_cnt <= '0;
			mode      <= MODE_ATT_L;
			busy      <= 1'b0;
		end else begin
			// follows the pins, which lag the strobes by one cycle
			busy <= (state != ST_IDLE);
			case (state)
				ST_IDLE: begin
					if (reload && !busy) begin
						state     <= ST_SHIFT;
						shift_cnt <= '0;
						mode      <= MODE_ATT_L;
					end
				end
				ST_RST: begin
					state    <= ST_RST_WAIT;
					wait_cnt <= '0;
				end
				ST_RST_WAIT: begin
					if (wait_cnt == WAIT_LAST) begin
						state     <= ST_SHIFT;
						shift_cnt <= '0;
						mode      <= MODE_ATT_L;
					end else begin
						wait_cnt <= wait_cnt + 8'd1;
					end
				end
				ST_SHIFT: begin
					shift_cnt <= shift_cnt + 5'd1;
					if (shift_cnt == SHIFT_LAST) begin
						state    <= ST_SHIFT_WAIT;
						wait_cnt <= '0;
					end
				end
				ST_SHIFT_WAIT: begin
					if (wait_cnt == WAIT_LAST) begin
						if (mode == MODE_FUNC) begin
							state <= ST_IDLE; // all three words sent
						end else begin
							state     <= ST_SHIFT;
							shift_cnt <= '0;
							mode      <= dac_mode_e'(mode + 2'd1);
						end
					end else begin
						wait_cnt <= wait_cnt + 8'd1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// word handed over in the first shift cycle
	assign ctl.load    = (state == ST_SHIFT) && (shift_cnt == '0);
	assign ctl.dac_rst = (state == ST_RST);
	assign ctl.latch   = (state == ST_SHIFT_WAIT) && (wait_cnt == LATCH_SLOT);

	// settings captured once per sequence, with the first word
	assign snap = ctl.load && (mode == MODE_ATT_L);

endmodule

// ==== hw/dac_serial_out.sv ====
`timescale 1ns/10ps

module dac_serial_out import dac_ctrl_pkg::*; (
	input  logic      clk_s,
	input  logic      rst,
	input  seq_ctl_t  ctl,
	input  dac_word_t word,
	output logic      dac_rst,
	output logic      mc,
	output logic      md,
	output logic      ml
);

	localparam int CNT_W = $clog2(WORD_BITS) + 1;
	localparam logic [CNT_W-1:0] CNT_DONE = CNT_W'(WORD_BITS);

	logic [WORD_BITS-1:0] sr;      // outgoing word, MSB on md
	logic                 phase;   // 0 is mc low half, 1 is mc high half
	logic [CNT_W-1:0]     bit_cnt; // bits already shifted out

	always_ff @(posedge clk_s) begin
		if (rst) begin
			sr      <= '0;
			phase   <= 1'b0;
			bit_cnt <= CNT_DONE;
			mc      <= 1'b0;
			dac_rst <= 1'b0;
			ml      <= 1'b1;
		end else begin
			dac_rst <= ctl.dac_rst;
			ml      <= ~ctl.latch; // active low latch

			if (ctl.load) begin
				sr      <= word;
				phase   <= 1'b0;
				bit_cnt <= '0;
				mc      <= 1'b0;
			end else if (bit_cnt != CNT_DONE) begin
				if (!phase) begin
					mc    <= 1'b1; // DAC samples md on this rise
					phase <= 1'b1;
				end else begin
					mc      <= 1'b0;
					phase   <= 1'b0;
					sr      <= {sr[WORD_BITS-2:0], 1'b0}; // zeros fill, md ends low
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	assign md = sr[WORD_BITS-1];

endmodule

// ==== hw/dac_word_build.sv ====
`timescale 1ns/10ps

module dac_word_build import dac_ctrl_pkg::*; (
	input  logic             clk_s,
	input  logic             rst,
	input  logic             snap,
	input  logic [ATT_W-1:0] att_l,
	input  logic [ATT_W-1:0] att_r,
	input  dac_func_t        func,
	input  dac_mode_e        mode,
	output dac_word_t        word
);

	logic [ATT_W-1:0] att_l_q;
	logic [ATT_W-1:0] att_r_q;
	dac_func_t        func_q;

	logic [ATT_W-1:0] sel_l;

	// settings held for the whole sequence
	always_ff @(posedge clk_s) begin
		if (rst) begin
			att_l_q <= '0;
			att_r_q <= '0;
			func_q  <= '0;
		end else if (snap) begin
			att_l_q <= att_l;
			att_r_q <= att_r;
			func_q  <= func;
		end
	end

	// first word loads in the snap cycle before the registers update
	assign sel_l = snap ? att_l : att_l_q;

	always_comb begin
		word.reserved = '0;
		word.mode     = mode;
		case (mode)
			MODE_ATT_L: word.data = sel_l;
			MODE_ATT_R: word.data = att_r_q;
			MODE_FUNC: begin
				// reset bit sits right after the output mode, kept at zero
				word.data = {func_q.out_mode, 1'b0, func_q.word_len, func_q.zero_mode,
					func_q.atten_common, func_q.mute, func_q.emph};
			end
			default: word.data = '0; // unused mode number
		endcase
	end

endmodule
